/* cell_switch.f */
hdl/switch_cfg_pkg.sv
hdl/switch_cell_pkg.sv
hdl/cell_rotator.sv
hdl/dest_filter.sv
hdl/cell_queue.sv
hdl/switch_ctrl.sv
hdl/cell_switch.sv
test/cell_switch_tb.sv

/* test/cell_switch_tb.sv */
`timescale 1ns/1ps

module cell_switch_tb
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROUNDS     = 7;
    localparam int READY_TIMEOUT  = 8 * PORT_COUNT;
    localparam int ARRIVE_TIMEOUT = 4 * PORT_COUNT;
    localparam int SETTLE_CYCLES  = PORT_COUNT + 2;
    localparam int BLOCK_WINDOW   = 6 * PORT_COUNT;
    localparam int MODEL_DEPTH    = 16;

    // one table row, dst[p] is the destination of input p
    typedef struct packed {
        logic [PORT_COUNT-1:0]      vld;
        port_sel_t [PORT_COUNT-1:0] dst;
        logic                       drain;
    } round_t;

    logic                                  clk;
    logic                                  rst_n;
    logic [PORT_COUNT-1:0]                 vld_in;
    port_sel_t [PORT_COUNT-1:0]            dst_in;
    logic [PORT_COUNT-1:0][DATA_WIDTH-1:0] data_in;
    port_sel_t [PORT_COUNT-1:0]            rd_sel;
    logic [PORT_COUNT-1:0]                 rd_en;
    logic [PORT_COUNT-1:0][DATA_WIDTH-1:0] data_out;
    logic                                  ready;
    logic [PORT_COUNT*PORT_COUNT-1:0]      empty;
    logic                                  full;
    logic                                  alm_ost_full;

    round_t                rounds [NUM_ROUNDS];
    logic [31:0]           rng_state;
    int                    n_errors;
    int                    n_checks;
    // reference model, one FIFO per output and source
    logic [DATA_WIDTH-1:0] model_mem  [PORT_COUNT][PORT_COUNT][MODEL_DEPTH];
    int                    model_head [PORT_COUNT][PORT_COUNT];
    int                    model_tail [PORT_COUNT][PORT_COUNT];

    cell_switch DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .vld_in       (vld_in),
        .dst_in       (dst_in),
        .data_in      (data_in),
        .rd_sel       (rd_sel),
        .rd_en        (rd_en),
        .data_out     (data_out),
        .ready        (ready),
        .empty        (empty),
        .full         (full),
        .alm_ost_full (alm_ost_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        n_errors++;
    endtask

    task automatic wait_for_ready(input int limit, output logic seen);
        int n;
        n = 0;
        while (!ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        seen = ready;
    endtask

    task automatic record_round();
        int o;
        for (int p = 0; p < PORT_COUNT; p++) begin
            if (vld_in[p]) begin
                o = dst_in[p];
                model_mem[o][p][model_tail[o][p] % MODEL_DEPTH] = data_in[p];
                model_tail[o][p]++;
            end
        end
    endtask

    // hold the cells until a ready edge takes them
    task automatic send_round(input round_t r);
        logic seen;
        for (int p = 0; p < PORT_COUNT; p++) begin
            rng_state = xorshift32(rng_state);
            data_in[p] = rng_state[DATA_WIDTH-1:0];
        end
        vld_in = r.vld;
        dst_in = r.dst;
        wait_for_ready(READY_TIMEOUT, seen);
        if (!seen) begin
            $display("Timeout at %0t ns: ready never came for a new round", $time);
            n_errors++;
        end else begin
            record_round();
        end
        @(negedge clk);
        vld_in = '0;
    endtask

    task automatic read_and_check(input int o, input int s);
        int                    n;
        logic [DATA_WIDTH-1:0] exp;
        n = 0;
        while (empty[o*PORT_COUNT+s] && n < ARRIVE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        exp = model_mem[o][s][model_head[o][s] % MODEL_DEPTH];
        model_head[o][s]++;
        if (empty[o*PORT_COUNT+s]) begin
            $display("Timeout at %0t ns: no cell from input %0d reached output %0d",
                     $time, s, o);
            n_errors++;
        end else begin
            rd_sel[o] = port_sel_t'(s);
            rd_en[o]  = 1'b1;
            @(negedge clk);
            rd_en[o] = 1'b0;
            n_checks++;
            if (data_out[o] !== exp) begin
                report_mismatch($sformatf("data_out[%0d] from input %0d", o, s),
                                exp, data_out[o]);
            end
        end
    endtask

    task automatic drain_all();
        for (int o = 0; o < PORT_COUNT; o++) begin
            for (int s = 0; s < PORT_COUNT; s++) begin
                while (model_head[o][s] < model_tail[o][s]) begin
                    read_and_check(o, s);
                end
            end
        end
    endtask

    // anything still arriving would clear an empty bit
    task automatic check_all_empty();
        repeat (SETTLE_CYCLES) @(negedge clk);
        n_checks++;
        if (empty !== '1) begin
            report_mismatch("empty", 16'hffff, empty);
        end
    endtask

    initial begin
        logic   seen;
        round_t bp;
        rst_n     = 1'b0;
        vld_in    = '0;
        dst_in    = '0;
        data_in   = '0;
        rd_sel    = '0;
        rd_en     = '0;
        n_errors  = 0;
        n_checks  = 0;
        rng_state = 32'd81805;
        for (int o = 0; o < PORT_COUNT; o++) begin
            for (int s = 0; s < PORT_COUNT; s++) begin
                model_head[o][s] = 0;
                model_tail[o][s] = 0;
            end
        end

        // vld, dst of ports 3..0, drain after the round
        rounds[0] = {4'b1111, 2'd0, 2'd1, 2'd2, 2'd3, 1'b1};
        rounds[1] = {4'b1111, 2'd3, 2'd2, 2'd1, 2'd0, 1'b1};
        // all inputs onto output 2
        rounds[2] = {4'b1111, 2'd2, 2'd2, 2'd2, 2'd2, 1'b1};
        // input 1 to output 0 three times, with invalid cells mixed in
        rounds[3] = {4'b0010, 2'd3, 2'd1, 2'd0, 2'd0, 1'b0};
        rounds[4] = {4'b1010, 2'd0, 2'd1, 2'd0, 2'd2, 1'b0};
        rounds[5] = {4'b0011, 2'd1, 2'd1, 2'd0, 2'd3, 1'b1};
        rounds[6] = {4'b0000, 2'd1, 2'd2, 2'd3, 2'd0, 1'b1};

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        n_checks += 5;
        if (ready !== 1'b0) report_mismatch("ready", 0, ready);
        if (full !== 1'b0) report_mismatch("full", 0, full);
        if (alm_ost_full !== 1'b0) report_mismatch("alm_ost_full", 0, alm_ost_full);
        if (empty !== '1) report_mismatch("empty", 16'hffff, empty);
        if (data_out !== '0) report_mismatch("data_out", 0, data_out);
        wait_for_ready(PORT_COUNT, seen);
        if (!seen) begin
            $display("Timeout at %0t ns: ready did not rise after reset", $time);
            n_errors++;
        end

        for (int i = 0; i < NUM_ROUNDS; i++) begin
            send_round(rounds[i]);
            if (rounds[i].drain) begin
                drain_all();
                check_all_empty();
            end
        end

        // input 2 fills its sub-queue at output 1
        bp = {4'b0100, 2'd1, 2'd1, 2'd1, 2'd1, 1'b0};
        for (int k = 1; k <= QUEUE_DEPTH; k++) begin
            send_round(bp);
            repeat (SETTLE_CYCLES) @(negedge clk);
            n_checks += 2;
            if (alm_ost_full !== (k >= ALMOST_FULL_LEVEL)) begin
                report_mismatch("alm_ost_full", k >= ALMOST_FULL_LEVEL, alm_ost_full);
            end
            if (full !== (k == QUEUE_DEPTH)) begin
                report_mismatch("full", k == QUEUE_DEPTH, full);
            end
        end
        wait_for_ready(BLOCK_WINDOW, seen);
        n_checks++;
        if (seen) begin
            $display("Error at %0t ns: ready rose while a sub-queue was full", $time);
            n_errors++;
        end
        read_and_check(1, 2);
        n_checks++;
        if (full !== 1'b0) report_mismatch("full", 0, full);
        wait_for_ready(READY_TIMEOUT, seen);
        if (!seen) begin
            $display("Timeout at %0t ns: ready did not return after a read", $time);
            n_errors++;
        end
        drain_all();
        check_all_empty();

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/cell_switch.sv */
`timescale 1ns/1ps

module cell_switch
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [PORT_COUNT-1:0]                  vld_in,
    input  port_sel_t [PORT_COUNT-1:0]             dst_in,
    input  logic [PORT_COUNT-1:0][DATA_WIDTH-1:0]  data_in,
    input  port_sel_t [PORT_COUNT-1:0]             rd_sel,
    input  logic [PORT_COUNT-1:0]                  rd_en,
    output logic [PORT_COUNT-1:0][DATA_WIDTH-1:0]  data_out,
    output logic                                   ready,
    output logic [PORT_COUNT*PORT_COUNT-1:0]       empty,
    output logic                                   full,
    output logic                                   alm_ost_full
);

    cell_t [PORT_COUNT-1:0]         cells_in;
    cell_t [PORT_COUNT-1:0]         lanes;
    queue_wr_t [PORT_COUNT-1:0]     wr;
    queue_status_t [PORT_COUNT-1:0] status;
    port_sel_t                      shift_sel;
    logic                           load;
    logic                           flush;

    // flat input buses into cells
    always_comb begin
        for (int p = 0; p < PORT_COUNT; p++) begin
            cells_in[p] = '{vld: vld_in[p], dst: dst_in[p], data: data_in[p]};
        end
    end

    switch_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .status       (status),
        .shift_sel    (shift_sel),
        .load         (load),
        .flush        (flush),
        .ready        (ready),
        .full         (full),
        .alm_ost_full (alm_ost_full)
    );

    cell_rotator u_rotator (
        .clk       (clk),
        .rst_n     (rst_n),
        .cells_in  (cells_in),
        .load      (load),
        .flush     (flush),
        .shift_sel (shift_sel),
        .lanes     (lanes)
    );

    dest_filter u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (lanes),
        .shift_sel (shift_sel),
        .wr        (wr)
    );

    // one egress queue set per output, empty bus is output-major
    for (genvar o = 0; o < PORT_COUNT; o++) begin : g_out
        cell_queue u_queue (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr      (wr[o]),
            .rd_en   (rd_en[o]),
            .rd_sel  (rd_sel[o]),
            .rd_data (data_out[o]),
            .status  (status[o])
        );

        assign empty[o*PORT_COUNT +: PORT_COUNT] = status[o].empty;
    end

endmodule

/* hdl/switch_ctrl.sv */
`timescale 1ns/1ps

module switch_ctrl
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  queue_status_t [PORT_COUNT-1:0] status,
    output port_sel_t                      shift_sel,
    output logic                           load,
    output logic                           flush,
    output logic                           ready,
    output logic                           full,
    output logic                           alm_ost_full
);

    port_sel_t round_cnt;
    logic      last_slot;
    logic      any_full;
    logic      any_alm;

    // free-running round counter, one lane offset per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_cnt <= '0;
        end else if (last_slot) begin
            round_cnt <= '0;
        end else begin
            round_cnt <= round_cnt + 1'b1;
        end
    end

    always_comb begin
        any_full = 1'b0;
        any_alm  = 1'b0;
        for (int o = 0; o < PORT_COUNT; o++) begin
            any_full = any_full | status[o].full;
            any_alm  = any_alm | status[o].alm_full;
        end
    end

    assign last_slot = (round_cnt == port_sel_t'(PORT_COUNT - 1));

    // new round only on the terminal count with room everywhere
    assign ready = last_slot && !any_full;
    assign load  = ready;

    // refused round must not replay the old held cells
    assign flush = last_slot && any_full;

    assign shift_sel    = round_cnt;
    assign full         = any_full;
    assign alm_ost_full = any_alm;

endmodule

/* hdl/cell_queue.sv */
`timescale 1ns/1ps

module cell_queue
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  queue_wr_t             wr,
    input  logic                  rd_en,
    input  port_sel_t             rd_sel,
    output logic [DATA_WIDTH-1:0] rd_data,
    output queue_status_t         status
);

    logic [DATA_WIDTH-1:0] mem    [PORT_COUNT][QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr [PORT_COUNT];
    logic [PTR_WIDTH-1:0]  rd_ptr [PORT_COUNT];
    logic [CNT_WIDTH-1:0]  count  [PORT_COUNT];

    logic [PORT_COUNT-1:0] push;
    logic [PORT_COUNT-1:0] pop;
    logic [PORT_COUNT-1:0] sq_empty;
    logic [PORT_COUNT-1:0] sq_full;
    logic [PORT_COUNT-1:0] sq_alm;

    // per sub-queue flags and strobes
    always_comb begin
        for (int s = 0; s < PORT_COUNT; s++) begin
            sq_empty[s] = (count[s] == 0);
            sq_full[s]  = (count[s] == QUEUE_DEPTH);
            sq_alm[s]   = (count[s] >= ALMOST_FULL_LEVEL);
            // full sub-queue refuses the write to keep its pointers sane
            push[s]     = wr.en && (wr.src == port_sel_t'(s)) && !sq_full[s];
            pop[s]      = rd_en && (rd_sel == port_sel_t'(s)) && !sq_empty[s];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < PORT_COUNT; s++) begin
                wr_ptr[s] <= '0;
                rd_ptr[s] <= '0;
                count[s]  <= '0;
            end
        end else begin
            for (int s = 0; s < PORT_COUNT; s++) begin
                if (push[s]) begin
                    wr_ptr[s] <= wr_ptr[s] + 1'b1;
                end
                if (pop[s]) begin
                    rd_ptr[s] <= rd_ptr[s] + 1'b1;
                end
                if (push[s] && !pop[s]) begin
                    count[s] <= count[s] + 1'b1;
                end else if (pop[s] && !push[s]) begin
                    count[s] <= count[s] - 1'b1;
                end
            end
        end
    end

    // at most one write per cycle, wr.src names the sub-queue
    always_ff @(posedge clk) begin
        if (|push) begin
            mem[wr.src][wr_ptr[wr.src]] <= wr.data;
        end
    end

    // popped byte stays until the next pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (|pop) begin
            rd_data <= mem[rd_sel][rd_ptr[rd_sel]];
        end
    end

    assign status = '{empty: sq_empty, full: |sq_full, alm_full: |sq_alm};

endmodule

/* hdl/dest_filter.sv */
`timescale 1ns/1ps

module dest_filter
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  cell_t [PORT_COUNT-1:0]     lanes,
    input  port_sel_t                  shift_sel,
    output queue_wr_t [PORT_COUNT-1:0] wr
);

    logic [PORT_COUNT-1:0]  wr_en_q;
    port_sel_t              src_q  [PORT_COUNT];
    logic [DATA_WIDTH-1:0]  data_q [PORT_COUNT];

    for (genvar d = 0; d < PORT_COUNT; d++) begin : g_lane
        port_sel_t src;

        // undo the rotation to get the input port back
        assign src = port_sel_t'(d) + shift_sel;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_en_q[d] <= 1'b0;
            end else begin
                wr_en_q[d] <= lanes[d].vld && (lanes[d].dst == port_sel_t'(d));
            end
        end

        always_ff @(posedge clk) begin
            src_q[d]  <= src;
            data_q[d] <= lanes[d].data;
        end

        assign wr[d] = '{en: wr_en_q[d], src: src_q[d], data: data_q[d]};
    end

endmodule

/* hdl/cell_rotator.sv */
`timescale 1ns/1ps

module cell_rotator
    import switch_cfg_pkg::*;
    import switch_cell_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  cell_t [PORT_COUNT-1:0]   cells_in,
    input  logic                     load,
    input  logic                     flush,
    input  port_sel_t                shift_sel,
    output cell_t [PORT_COUNT-1:0]   lanes
);

    cell_t [PORT_COUNT-1:0] held;
    cell_t [PORT_COUNT-1:0] stage [SEL_WIDTH+1];

    // round hold register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else if (load) begin
            held <= cells_in;
        end else if (flush) begin
            for (int i = 0; i < PORT_COUNT; i++) begin
                held[i].vld <= 1'b0;
            end
        end
    end

    // log2(N) stages, stage s rotates by 2**s
    assign stage[0] = held;

    for (genvar s = 0; s < SEL_WIDTH; s++) begin : g_stage
        for (genvar d = 0; d < PORT_COUNT; d++) begin : g_lane
            assign stage[s+1][d] = shift_sel[s] ?
                                   stage[s][(d + (1 << s)) % PORT_COUNT] :
                                   stage[s][d];
        end
    end

    // lane d now carries held cell (d + shift_sel) mod N
    assign lanes = stage[SEL_WIDTH];

endmodule

/* hdl/switch_cell_pkg.sv */
package switch_cell_pkg;

    import switch_cfg_pkg::*;

    typedef logic [SEL_WIDTH-1:0] port_sel_t;

    // one cell as presented on an input port
    typedef struct packed {
        logic                  vld;
        port_sel_t             dst;
        logic [DATA_WIDTH-1:0] data;
    } cell_t;

    // single write into one output port, src picks the sub-queue
    typedef struct packed {
        logic                  en;
        port_sel_t             src;
        logic [DATA_WIDTH-1:0] data;
    } queue_wr_t;

    typedef struct packed {
        logic [PORT_COUNT-1:0] empty;
        logic                  full;
        logic                  alm_full;
    } queue_status_t;

endpackage

/* hdl/switch_cfg_pkg.sv */
package switch_cfg_pkg;

    // switch geometry
    localparam int PORT_COUNT = 4;
    localparam int SEL_WIDTH  = $clog2(PORT_COUNT);
    localparam int DATA_WIDTH = 8;

    // egress sub-queue sizing
    localparam int QUEUE_DEPTH       = 4;
    localparam int ALMOST_FULL_LEVEL = 3;

    // pointer and occupancy widths of one sub-queue
    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

endpackage
